// File: design/div_pkg.sv
package div_pkg;

    // operand and result width.
    localparam int xlen = 64;

    // one quotient bit per clock.
    localparam int iter_count = 64;

    typedef logic [xlen-1:0] xlen_t;

    // narrowed dividend, kept for the special-case results.
    typedef xlen_t div_orig_t;

    typedef enum logic [2:0] {
        DIV   = 3'd0,
        DIVU  = 3'd1,
        REM   = 3'd2,
        REMU  = 3'd3,
        DIVW  = 3'd4,
        DIVUW = 3'd5,
        REMW  = 3'd6,
        REMUW = 3'd7
    } div_op_e;

    typedef enum logic [1:0] {
        SPEC_NONE     = 2'd0,
        SPEC_DIV_ZERO = 2'd1,
        SPEC_OVERFLOW = 2'd2
    } div_special_e;

    // travels with the operation through the divider.
    typedef struct packed {
        logic         neg_quot;
        logic         neg_rem;
        logic         want_rem;
        logic         word;
        div_special_e special;
    } div_tag_t;

endpackage

// File: design/div_if.sv
`timescale 1ns/1ps

// prep to divider core.
interface div_req_if;
    logic               valid;
    div_pkg::xlen_t     dividend_mag;
    div_pkg::xlen_t     divisor_mag;
    div_pkg::div_orig_t orig_dividend;
    div_pkg::div_tag_t  tag;

    modport source (
        output valid, dividend_mag, divisor_mag, orig_dividend, tag
    );

    modport sink (
        input valid, dividend_mag, divisor_mag, orig_dividend, tag
    );
endinterface

// divider core to result formatter.
interface div_res_if;
    logic               valid;
    div_pkg::xlen_t     quotient;
    div_pkg::xlen_t     remainder;
    div_pkg::div_orig_t orig_dividend;
    div_pkg::div_tag_t  tag;

    modport source (
        output valid, quotient, remainder, orig_dividend, tag
    );

    modport sink (
        input valid, quotient, remainder, orig_dividend, tag
    );
endinterface

// File: design/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  div_pkg::div_op_e op,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    input  logic             accept,
    output logic             pending,
    div_req_if.source        req
);

    logic                  capture;
    logic                  is_word;
    logic                  is_signed;
    logic                  want_rem;
    logic                  a_neg;
    logic                  b_neg;
    logic                  valid_q;
    div_pkg::xlen_t        a_nar;
    div_pkg::xlen_t        b_nar;
    div_pkg::xlen_t        min_neg;
    div_pkg::div_special_e special;
    div_pkg::div_tag_t     tag_d;

    assign capture   = start && accept;
    assign is_word   = op inside {div_pkg::DIVW, div_pkg::DIVUW, div_pkg::REMW, div_pkg::REMUW};
    assign is_signed = op inside {div_pkg::DIV, div_pkg::REM, div_pkg::DIVW, div_pkg::REMW};
    assign want_rem  = op inside {div_pkg::REM, div_pkg::REMU, div_pkg::REMW, div_pkg::REMUW};

    // word forms only see the low 32 bits.
    always_comb begin
        if (!is_word) begin
            a_nar = dividend;
            b_nar = divisor;
        end else if (is_signed) begin
            a_nar = {{32{dividend[31]}}, dividend[31:0]};
            b_nar = {{32{divisor[31]}}, divisor[31:0]};
        end else begin
            a_nar = {32'b0, dividend[31:0]};
            b_nar = {32'b0, divisor[31:0]};
        end
    end

    assign a_neg   = is_signed && a_nar[div_pkg::xlen-1];
    assign b_neg   = is_signed && b_nar[div_pkg::xlen-1];
    assign min_neg = is_word ? {{33{1'b1}}, 31'b0} : {1'b1, {(div_pkg::xlen-1){1'b0}}};

    always_comb begin
        if (b_nar == '0) begin
            special = div_pkg::SPEC_DIV_ZERO;
        end else if (is_signed && a_nar == min_neg && b_nar == '1) begin
            special = div_pkg::SPEC_OVERFLOW;
        end else begin
            special = div_pkg::SPEC_NONE;
        end
        tag_d.neg_quot = a_neg ^ b_neg;
        tag_d.neg_rem  = a_neg;   // remainder follows the dividend.
        tag_d.want_rem = want_rem;
        tag_d.word     = is_word;
        tag_d.special  = special;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req.dividend_mag  <= a_neg ? -a_nar : a_nar;
            req.divisor_mag   <= b_neg ? -b_nar : b_nar;
            req.orig_dividend <= a_nar;
            req.tag           <= tag_d;
        end
    end

    assign req.valid = valid_q;
    assign pending   = valid_q;

    // every 3-bit encoding is an op, so only an unknown value is illegal.
    a_cap_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> !$isunknown(op));

endmodule

// File: design/div_iter_core.sv
`timescale 1ns/1ps

module div_iter_core (
    input  logic      clk,
    input  logic      rst_n,
    div_req_if.sink   req,
    output logic      running,
    div_res_if.source res
);

    localparam int rq_w = 2 * div_pkg::xlen;

    // upper half partial remainder, lower half quotient.
    logic [rq_w-1:0]    rq;
    logic [rq_w-1:0]    rq_shl;
    logic [6:0]         cnt;
    logic               iterating;
    logic               last_iter;
    logic               fits;
    logic               res_valid;
    div_pkg::xlen_t     divisor_q;
    div_pkg::xlen_t     upper_shl;
    div_pkg::div_orig_t orig_q;
    div_pkg::div_tag_t  tag_q;

    assign rq_shl    = {rq[rq_w-2:0], 1'b0};
    assign upper_shl = rq_shl[rq_w-1:div_pkg::xlen];
    assign fits      = upper_shl >= divisor_q;

    assign iterating = running && (cnt < 7'(div_pkg::iter_count));
    assign last_iter = running && (cnt == 7'(div_pkg::iter_count - 1));

    // counter runs two past the last iteration so busy covers done.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            cnt       <= 7'd0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= last_iter;
            if (req.valid) begin
                running <= 1'b1;
                cnt     <= 7'd0;
            end else if (running) begin
                if (cnt == 7'(div_pkg::iter_count + 1)) begin
                    running <= 1'b0;
                end else begin
                    cnt <= cnt + 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rq        <= {{div_pkg::xlen{1'b0}}, req.dividend_mag};
            divisor_q <= req.divisor_mag;
            orig_q    <= req.orig_dividend;
            tag_q     <= req.tag;
        end else if (iterating) begin
            if (fits) begin
                rq <= {upper_shl - divisor_q, rq_shl[div_pkg::xlen-1:1], 1'b1};
            end else begin
                rq <= rq_shl;
            end
        end
    end

    assign res.valid         = res_valid;
    assign res.quotient      = rq[div_pkg::xlen-1:0];
    assign res.remainder     = rq[rq_w-1:div_pkg::xlen];
    assign res.orig_dividend = orig_q;
    assign res.tag           = tag_q;

    // one operation at a time.
    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> !running);

    // result follows the load by the full iteration count.
    a_res_timing: assert property (@(posedge clk) disable iff (!rst_n)
        res.valid |-> $past(req.valid, div_pkg::iter_count + 1));

endmodule

// File: design/div_result_fmt.sv
`timescale 1ns/1ps

module div_result_fmt (
    input  logic           clk,
    input  logic           rst_n,
    div_res_if.sink        res,
    output logic           done,
    output div_pkg::xlen_t result
);

    logic           neg;
    div_pkg::xlen_t sel;
    div_pkg::xlen_t signed_val;
    div_pkg::xlen_t fixed_val;
    div_pkg::xlen_t final_val;

    always_comb begin
        if (res.tag.want_rem) begin
            sel = res.remainder;
            neg = res.tag.neg_rem;
        end else begin
            sel = res.quotient;
            neg = res.tag.neg_quot;
        end
        signed_val = neg ? -sel : sel;
    end

    // riscv rules for zero divisor and signed overflow.
    always_comb begin
        case (res.tag.special)
            div_pkg::SPEC_DIV_ZERO: begin
                fixed_val = res.tag.want_rem ? res.orig_dividend : '1;
            end
            div_pkg::SPEC_OVERFLOW: begin
                fixed_val = res.tag.want_rem ? '0 : res.orig_dividend;
            end
            default: begin
                fixed_val = signed_val;
            end
        endcase
    end

    // word results always sign-extend, unsigned forms too.
    assign final_val = res.tag.word ? {{32{fixed_val[31]}}, fixed_val[31:0]} : fixed_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= res.valid;
            if (res.valid) begin
                result <= final_val;
            end
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  div_pkg::div_op_e op,
    input  div_pkg::xlen_t   dividend,
    input  div_pkg::xlen_t   divisor,
    output logic             busy,
    output logic             done,
    output div_pkg::xlen_t   result
);

    logic pending;
    logic running;
    logic accept;

    div_req_if req_if ();
    div_res_if res_if ();

    // busy spans prep capture through the done cycle.
    assign busy   = pending | running;
    assign accept = ~busy;

    div_operand_prep u_prep (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .accept   (accept),
        .pending  (pending),
        .req      (req_if.source)
    );

    div_iter_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req_if.sink),
        .running (running),
        .res     (res_if.source)
    );

    div_result_fmt u_fmt (
        .clk    (clk),
        .rst_n  (rst_n),
        .res    (res_if.sink),
        .done   (done),
        .result (result)
    );

endmodule

// File: tests/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

    localparam int done_latency = 66;
    localparam int done_timeout = 100;

    logic             clk;
    logic             rst_n;
    logic             start;
    div_pkg::div_op_e op;
    div_pkg::xlen_t   dividend;
    div_pkg::xlen_t   divisor;
    logic             busy;
    logic             done;
    div_pkg::xlen_t   result;

    logic [31:0]      lfsr_state;
    div_pkg::div_op_e cur_op;
    div_pkg::xlen_t   cur_a;
    div_pkg::xlen_t   cur_b;
    int               result_errors;
    int               latency_errors;
    int               flag_errors;
    int               timeouts;

    div_unit uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    // riscv m-extension reference.
    function automatic div_pkg::xlen_t model(input div_pkg::div_op_e o,
                                             input div_pkg::xlen_t a,
                                             input div_pkg::xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic [31:0]        ua;
        logic [31:0]        ub;
        logic [31:0]        w;
        logic               word_op;
        logic               ovf;
        logic               wovf;
        div_pkg::xlen_t     r;
        sa = a;
        sb = b;
        wa = a[31:0];
        wb = b[31:0];
        ua = a[31:0];
        ub = b[31:0];
        ovf = (a == 64'h8000_0000_0000_0000) && (b == '1);
        wovf = (ua == 32'h8000_0000) && (ub == '1);
        w = '0;
        r = '0;
        word_op = 1'b1;
        // signed quotients and remainders are formed on their own, then mixed in.
        case (o)
            div_pkg::DIV:   r = (b == '0) ? '1 : (ovf ? a : $unsigned(sa / sb));
            div_pkg::DIVU:  r = (b == '0) ? '1 : a / b;
            div_pkg::REM:   r = (b == '0) ? a : (ovf ? '0 : $unsigned(sa % sb));
            div_pkg::REMU:  r = (b == '0) ? a : a % b;
            div_pkg::DIVW:  w = (ub == '0) ? '1 : (wovf ? ua : $unsigned(wa / wb));
            div_pkg::DIVUW: w = (ub == '0) ? '1 : ua / ub;
            div_pkg::REMW:  w = (ub == '0) ? ua : (wovf ? '0 : $unsigned(wa % wb));
            default:        w = (ub == '0) ? ua : ua % ub;
        endcase
        if (o inside {div_pkg::DIV, div_pkg::DIVU, div_pkg::REM, div_pkg::REMU}) begin
            word_op = 1'b0;
        end
        if (word_op) begin
            r = {{32{w[31]}}, w};
        end
        return r;
    endfunction

    task automatic check_result(input div_pkg::xlen_t exp_v, input div_pkg::xlen_t got,
                                input string what);
        if (got !== exp_v) begin
            result_errors++;
            $display("** Error at %0t: %s op=%s a=%h b=%h expected %h got %h",
                     $time, what, cur_op.name(), cur_a, cur_b, exp_v, got);
        end
    endtask

    task automatic check_latency(input int exp_v, input int got);
        if (got != exp_v) begin
            latency_errors++;
            $display("** Error at %0t: done latency op=%s a=%h b=%h expected %0d got %0d",
                     $time, cur_op.name(), cur_a, cur_b, exp_v, got);
        end
    endtask

    task automatic check_flag(input logic exp_v, input logic got, input string what);
        if (got !== exp_v) begin
            flag_errors++;
            $display("** Error at %0t: %s op=%s a=%h b=%h expected %b got %b",
                     $time, what, cur_op.name(), cur_a, cur_b, exp_v, got);
        end
    endtask

    // biased toward zero and small divisors and the most negative dividend.
    task automatic make_operands(input div_pkg::div_op_e o, output div_pkg::xlen_t a,
                                 output div_pkg::xlen_t b);
        logic [63:0] pick;
        logic [63:0] ra;
        logic [63:0] rb;
        logic        is_word;
        draw_bits(3, pick);
        draw_bits(64, ra);
        draw_bits(64, rb);
        is_word = o inside {div_pkg::DIVW, div_pkg::DIVUW, div_pkg::REMW, div_pkg::REMUW};
        case (pick[2:0])
            3'd0: rb = is_word ? {rb[63:32], 32'h0} : '0;
            3'd1, 3'd2: rb = is_word ? {rb[63:32], {24{rb[7]}}, rb[7:0]} : {{56{rb[7]}}, rb[7:0]};
            3'd3: begin
                ra = is_word ? {ra[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
                rb = is_word ? {rb[63:32], 32'hffff_ffff} : '1;
            end
            3'd4: ra = is_word ? {ra[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
            default: ;
        endcase
        a = ra;
        b = rb;
    endtask

    // poke_busy pulses a second start mid-run, which must be ignored.
    task automatic run_op(input div_pkg::div_op_e o, input div_pkg::xlen_t a,
                          input div_pkg::xlen_t b, input bit poke_busy);
        div_pkg::xlen_t expected;
        div_pkg::xlen_t held;
        int             cycles;
        int             idle;
        bit             seen;
        cur_op = o;
        cur_a = a;
        cur_b = b;
        expected = model(o, a, b);
        held = result;
        cycles = 0;
        seen = 1'b0;
        idle = poke_busy ? 80 : 1;
        @(posedge clk);
        start <= 1'b1;
        op <= o;
        dividend <= a;
        divisor <= b;
        // cycles counts edges after the one that samples start.
        while (!seen && cycles < done_timeout) begin
            @(posedge clk);
            start <= poke_busy && (cycles == 9);
            op <= div_pkg::DIVU;
            dividend <= ~a;
            divisor <= 64'd3;
            @(negedge clk);
            check_flag(1'b1, busy, "busy during run");
            if (done) begin
                seen = 1'b1;
            end else begin
                check_result(held, result, "result held before done");
                cycles++;
            end
        end
        if (seen) begin
            check_latency(done_latency, cycles);
            check_result(expected, result, "result");
        end else begin
            timeouts++;
            $display("timeout: no done within %0d cycles for op %s", done_timeout, o.name());
        end
        for (int i = 0; i < idle; i++) begin
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            check_flag(1'b0, done, "done after completion");
            check_flag(1'b0, busy, "busy after completion");
            check_result(expected, result, "result held after done");
        end
    endtask

    initial begin
        div_pkg::div_op_e o;
        logic [63:0]      pick;
        div_pkg::xlen_t   a;
        div_pkg::xlen_t   b;
        rst_n = 1'b0;
        start = 1'b0;
        op = div_pkg::DIV;
        dividend = '0;
        divisor = '0;
        lfsr_state = 32'd92827;
        cur_op = div_pkg::DIV;
        cur_a = '0;
        cur_b = '0;
        result_errors = 0;
        latency_errors = 0;
        flag_errors = 0;
        timeouts = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(1'b0, busy, "busy after reset");
        check_flag(1'b0, done, "done after reset");
        check_result('0, result, "result after reset");

        // zero divisor and signed overflow for every op.
        for (int k = 0; k < 8; k++) begin
            o = div_pkg::div_op_e'(k[2:0]);
            draw_bits(64, a);
            run_op(o, a, (k >= 4) ? 64'hdead_beef_0000_0000 : '0, 1'b0);
            if (k >= 4) begin
                run_op(o, 64'h0123_4567_8000_0000, 64'h0000_0042_ffff_ffff, 1'b0);
            end else begin
                run_op(o, 64'h8000_0000_0000_0000, '1, 1'b0);
            end
        end

        run_op(div_pkg::DIV, 64'hffff_ffff_ffff_ff9c, 64'd7, 1'b1);

        for (int n = 0; n < 240; n++) begin
            draw_bits(2, pick);
            o = div_pkg::div_op_e'({(n >= 120), pick[1:0]});
            make_operands(o, a, b);
            run_op(o, a, b, 1'b0);
        end

        $display("errors: result %0d, latency %0d, flag %0d, timeout %0d",
                 result_errors, latency_errors, flag_errors, timeouts);
        if (result_errors + latency_errors + flag_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: files.f
design/div_pkg.sv
design/div_if.sv
design/div_operand_prep.sv
design/div_iter_core.sv
design/div_result_fmt.sv
design/div_unit.sv
tests/div_unit_tb.sv

// File: Makefile
# Verilator build and run for the divide unit testbench.

VERILATOR ?= verilator
TOP       ?= div_unit_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qxF '** PASS **' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
